//--- all.f
verilog/sl_link_pkg.sv
verilog/sl_mgmt_pkg.sv
verilog/sl_lane_deskew.sv
verilog/sl_burst_decode.sv
verilog/sl_mgmt_regs.sv
verilog/sl_stream_sink.sv
dv/tb_sl_stream_sink.sv

//--- dv/tb_sl_stream_sink.sv
// directed testbench for the streaming sink with lane drivers, axi host and beat checker
`timescale 1ns/1ns

module tb_sl_stream_sink
   import sl_link_pkg::*, sl_mgmt_pkg::*;
();

   localparam int lanes      = 4;
   localparam int fifo_depth = 8;
   localparam int dw         = lanes * word_w;
   localparam int max_skew   = 3;
   // tests take under 2000 cycles, limit is about ten times that
   localparam int max_cycles = 20000;
   // link_up and aligned both set
   localparam logic [31:0] status_up = (32'd1 << st_link_up) | (32'd1 << st_aligned);

   logic              clock;
   logic              reset;
   logic [dw-1:0]     lane_data;
   logic [lanes-1:0]  lane_ctrl;
   logic [lanes-1:0]  lane_valid;
   logic [dw-1:0]     data;
   logic [3:0]        sync;
   logic              valid;
   logic              start_of_burst;
   logic              end_of_burst;
   logic              link_up;
   logic [7:0]        awaddr;
   logic              awvalid;
   logic              awready;
   logic [31:0]       wdata;
   logic [3:0]        wstrb;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [7:0]        araddr;
   logic              arvalid;
   logic              arready;
   logic [31:0]       rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   // rows waiting to go out on the lanes, lane 0 in the low bits
   logic [dw-1:0]     row_q [$];
   logic [lanes-1:0]  ctrl_q [$];
   // expected beats packed as sob, eob, sync, data
   logic [dw+5:0]     exp_q [$];
   logic [dw+5:0]     beat;
   int                skew [lanes];
   int                cycles = 0;

   sl_stream_sink #(
      .lanes      (lanes),
      .fifo_depth (fifo_depth)
   ) u_sl_stream_sink (
      .clock          (clock),
      .reset          (reset),
      .lane_data      (lane_data),
      .lane_ctrl      (lane_ctrl),
      .lane_valid     (lane_valid),
      .data           (data),
      .sync           (sync),
      .valid          (valid),
      .start_of_burst (start_of_burst),
      .end_of_burst   (end_of_burst),
      .link_up        (link_up),
      .awaddr         (awaddr),
      .awvalid        (awvalid),
      .awready        (awready),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .wvalid         (wvalid),
      .wready         (wready),
      .bresp          (bresp),
      .bvalid         (bvalid),
      .bready         (bready),
      .araddr         (araddr),
      .arvalid        (arvalid),
      .arready        (arready),
      .rdata          (rdata),
      .rresp          (rresp),
      .rvalid         (rvalid),
      .rready         (rready)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("test failed");
      $fatal(1, "run stopped");
   endtask

   task automatic value_error(input string msg);
      stop_run($sformatf("** Error at %0t ns: %s", $time, msg));
   endtask

   // run length guard
   always @(posedge clock) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         stop_run($sformatf("timeout, run went past %0d cycles", max_cycles));
      end
   end

   // beat checker, sampled mid cycle
   always @(negedge clock) begin
      if (!reset && valid) begin
         assert (exp_q.size() != 0)
            else stop_run($sformatf("output beat at %0t ns with no row expected", $time));
         beat = exp_q.pop_front();
         assert (data == beat[dw-1:0])
            else value_error($sformatf("data %h expected %h", data, beat[dw-1:0]));
         assert (sync == beat[dw+3:dw])
            else value_error($sformatf("sync %h expected %h", sync, beat[dw+3:dw]));
         assert (start_of_burst == beat[dw+5])
            else value_error($sformatf("start_of_burst %b expected %b",
                                       start_of_burst, beat[dw+5]));
         assert (end_of_burst == beat[dw+4])
            else value_error($sformatf("end_of_burst %b expected %b",
                                       end_of_burst, beat[dw+4]));
      end
   end

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] value);
      @(posedge clock);
      #2;
      awaddr  = addr;
      wdata   = value;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      // both ready pulse together
      @(negedge clock);
      while (!awready) @(negedge clock);
      assert (wready)
         else value_error($sformatf("wready low with awready high on write to %h", addr));
      @(posedge clock);
      #2;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      @(negedge clock);
      while (!bvalid) @(negedge clock);
      assert (bresp == resp_okay)
         else value_error($sformatf("write to %h gave response %0d", addr, bresp));
      @(posedge clock);
      #2;
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] value,
                           output logic [1:0] resp);
      @(posedge clock);
      #2;
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clock);
      while (!arready) @(negedge clock);
      @(posedge clock);
      #2;
      arvalid = 1'b0;
      rready  = 1'b1;
      // data one cycle after the handshake
      @(negedge clock);
      while (!rvalid) @(negedge clock);
      value = rdata;
      resp  = rresp;
      @(posedge clock);
      #2;
      rready = 1'b0;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
      logic [31:0] got;
      logic [1:0]  resp;
      axi_read(addr, got, resp);
      assert (resp == resp_okay)
         else value_error($sformatf("read of %h gave response %0d", addr, resp));
      assert (got == expected)
         else value_error($sformatf("register %h read %h expected %h", addr, got, expected));
   endtask

   // same control word on every lane
   task automatic push_ctrl_row(input ctrl_type_e t, input logic [3:0] s,
                                input logic [15:0] len);
      ctrl_word_t    cw;
      logic [dw-1:0] d;
      cw.ctrl_type = t;
      cw.sync      = s;
      cw.burst_len = len;
      cw.reserved  = '0;
      for (int i = 0; i < lanes; i++) begin
         d[i*word_w +: word_w] = cw;
      end
      row_q.push_back(d);
      ctrl_q.push_back('1);
   endtask

   // lane i runs skew[i] cycles behind, one word per cycle
   task automatic drive_rows();
      int n;
      int k;
      n = row_q.size();
      for (int c = 0; c < n + max_skew; c++) begin
         @(posedge clock);
         #2;
         for (int i = 0; i < lanes; i++) begin
            k = c - skew[i];
            if (k >= 0 && k < n) begin
               lane_valid[i]             = 1'b1;
               lane_ctrl[i]              = ctrl_q[k][i];
               lane_data[i*word_w +: word_w] = row_q[k][i*word_w +: word_w];
            end else begin
               lane_valid[i] = 1'b0;
            end
         end
      end
      @(posedge clock);
      #2;
      lane_valid = '0;
      row_q.delete();
      ctrl_q.delete();
   endtask

   // fresh skews, then marker and idle rows
   task automatic align_lanes();
      for (int i = 0; i < lanes; i++) begin
         skew[i] = $urandom % (max_skew + 1);
      end
      push_ctrl_row(ct_align, 4'd0, 16'd0);
      push_ctrl_row(ct_idle, 4'd0, 16'd0);
      drive_rows();
      while (!link_up) @(negedge clock);
   endtask

   // start row, nrows data rows, end row carrying len_field
   task automatic send_burst(input int nrows, input int len_field, input bit expect_out);
      logic [dw-1:0] d;
      logic [3:0]    s;
      s = 4'($urandom % 16);
      push_ctrl_row(ct_burst_start, s, 16'd0);
      for (int r = 0; r < nrows; r++) begin
         for (int i = 0; i < lanes; i++) begin
            d[i*word_w +: word_w] = {$urandom, $urandom};
         end
         row_q.push_back(d);
         ctrl_q.push_back('0);
         if (expect_out) begin
            exp_q.push_back({r == 0, r == nrows - 1, s, d});
         end
      end
      push_ctrl_row(ct_burst_end, 4'd0, 16'(len_field));
      drive_rows();
   endtask

   // data words on every lane but one
   task automatic flood_lanes(input int quiet, input int n);
      for (int c = 0; c < n; c++) begin
         @(posedge clock);
         #2;
         for (int i = 0; i < lanes; i++) begin
            lane_valid[i]             = (i != quiet);
            lane_ctrl[i]              = 1'b0;
            lane_data[i*word_w +: word_w] = {$urandom, $urandom};
         end
      end
      @(posedge clock);
      #2;
      lane_valid = '0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(posedge clock);
      // room for a stray beat to reach the checker
      repeat (4) @(posedge clock);
   endtask

   task automatic reset_values();
      logic [31:0] got;
      logic [1:0]  resp;
      check_reg(reg_id, 32'(lanes));
      check_reg(reg_status, 32'd0);
      check_reg(reg_ctrl, 32'd1);
      axi_read(8'h40, got, resp);
      assert (resp == resp_slverr)
         else value_error($sformatf("unmapped read gave response %0d", resp));
   endtask

   task automatic three_bursts();
      int n;
      align_lanes();
      check_reg(reg_status, status_up);
      repeat (3) begin
         n = 1 + $urandom % 6;
         send_burst(n, n, 1'b1);
      end
      wait_drain();
      assert (link_up)
         else value_error("link_up low after clean bursts");
      check_reg(reg_bursts, 32'd3);
      check_reg(reg_len_err, 32'd0);
   endtask

   task automatic length_mismatch();
      logic [31:0] base;
      logic [1:0]  resp;
      int          n;
      axi_read(reg_len_err, base, resp);
      n = 1 + $urandom % 6;
      // end word claims two rows more than were sent
      send_burst(n, n + 2, 1'b1);
      wait_drain();
      check_reg(reg_len_err, base + 32'd1);
   endtask

   task automatic skew_overflow();
      logic [31:0] base;
      logic [1:0]  resp;
      int          n;
      axi_read(reg_skew_err, base, resp);
      flood_lanes($urandom % lanes, fifo_depth + 2);
      check_reg(reg_skew_err, base + 32'd1);
      check_reg(reg_status, 32'd0);
      // link comes back after a new marker
      align_lanes();
      n = 1 + $urandom % 6;
      send_burst(n, n, 1'b1);
      wait_drain();
   endtask

   task automatic link_disable();
      int n;
      axi_write(reg_ctrl, 32'd0);
      check_reg(reg_ctrl, 32'd0);
      assert (!link_up)
         else value_error("link_up high with enable low");
      // nothing expected, any beat trips the checker
      send_burst(3, 3, 1'b0);
      send_burst(2, 2, 1'b0);
      repeat (8) @(posedge clock);
      axi_write(reg_ctrl, 32'd1);
      align_lanes();
      n = 1 + $urandom % 6;
      send_burst(n, n, 1'b1);
      wait_drain();
   endtask

   task automatic counter_clear();
      logic [7:0] addrs [3];
      addrs = '{reg_bursts, reg_len_err, reg_skew_err};
      foreach (addrs[j]) begin
         // any written value clears the count
         axi_write(addrs[j], 32'hFFFF_FFFF);
         check_reg(addrs[j], 32'd0);
      end
   endtask

   initial begin
      void'($urandom(68));
      reset      = 1'b1;
      lane_data  = '0;
      lane_ctrl  = '0;
      lane_valid = '0;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      repeat (16) @(posedge clock);
      #2;
      reset = 1'b0;
      reset_values();
      three_bursts();
      length_mismatch();
      skew_overflow();
      link_disable();
      counter_clear();
      if (exp_q.size() == 0) begin
         $display("test passed");
         $finish;
      end else begin
         stop_run("expected output rows were never delivered");
      end
   end

endmodule

//--- verilog/sl_stream_sink.sv
// streaming sink top joining lane deskew, burst decode and management registers
`timescale 1ns/1ns

module sl_stream_sink
   import sl_link_pkg::*;
#(
   parameter int lanes      = 4,
   parameter int fifo_depth = 8
) (
   input  logic                      clock,
   input  logic                      reset,
   // deserialized lanes
   input  logic [lanes*word_w-1:0]   lane_data,
   input  logic [lanes-1:0]          lane_ctrl,
   input  logic [lanes-1:0]          lane_valid,
   // user stream
   output logic [lanes*word_w-1:0]   data,
   output logic [3:0]                sync,
   output logic                      valid,
   output logic                      start_of_burst,
   output logic                      end_of_burst,
   output logic                      link_up,
   // axi4-lite management
   input  logic [7:0]                awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [31:0]               wdata,
   input  logic [3:0]                wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [7:0]                araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [31:0]               rdata,
   output logic [1:0]                rresp,
   output logic                      rvalid,
   input  logic                      rready
);

   logic [lanes*word_w-1:0] row_data;
   logic [lanes-1:0]        row_ctrl;
   logic                    row_valid;
   logic                    aligned;
   logic                    skew_error;
   logic                    len_error;
   logic                    burst_done;
   logic                    enable;

   sl_lane_deskew #(
      .lanes      (lanes),
      .fifo_depth (fifo_depth)
   ) u_sl_lane_deskew (
      .clock      (clock),
      .reset      (reset),
      .enable     (enable),
      .lane_data  (lane_data),
      .lane_ctrl  (lane_ctrl),
      .lane_valid (lane_valid),
      .row_data   (row_data),
      .row_ctrl   (row_ctrl),
      .row_valid  (row_valid),
      .aligned    (aligned),
      .skew_error (skew_error)
   );

   sl_burst_decode #(
      .lanes          (lanes)
   ) u_sl_burst_decode (
      .clock          (clock),
      .reset          (reset),
      .enable         (enable),
      .row_valid      (row_valid),
      .aligned        (aligned),
      .row_data       (row_data),
      .row_ctrl       (row_ctrl),
      .data           (data),
      .sync           (sync),
      .valid          (valid),
      .start_of_burst (start_of_burst),
      .end_of_burst   (end_of_burst),
      .link_up        (link_up),
      .len_error      (len_error),
      .burst_done     (burst_done)
   );

   sl_mgmt_regs #(
      .lanes      (lanes)
   ) u_sl_mgmt_regs (
      .clock      (clock),
      .reset      (reset),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .link_up    (link_up),
      .aligned    (aligned),
      .skew_error (skew_error),
      .len_error  (len_error),
      .burst_done (burst_done),
      .enable     (enable)
   );

endmodule

//--- verilog/sl_mgmt_regs.sv
// axi4-lite management slave with control, link status and error counters
`timescale 1ns/1ns

module sl_mgmt_regs
   import sl_mgmt_pkg::*;
#(
   parameter int lanes = 4
) (
   input  logic        clock,
   input  logic        reset,
   input  logic [7:0]  awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [7:0]  araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   input  logic        link_up,
   input  logic        aligned,
   input  logic        skew_error,
   input  logic        len_error,
   input  logic        burst_done,
   output logic        enable
);

   logic [31:0] bursts;
   logic [31:0] len_errs;
   logic [31:0] skew_errs;
   logic [31:0] rd_word;
   logic        wr_hs;
   logic        rd_hs;
   logic        wr_any;

   function automatic logic mapped(input logic [7:0] addr);
      case (addr)
         reg_ctrl, reg_status, reg_bursts, reg_len_err, reg_skew_err, reg_id: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // saturating count, a write clears it
   function automatic logic [31:0] next_count(input logic [31:0] cnt, input logic inc,
                                              input logic clr);
      if (clr) return '0;
      if (inc && (cnt != '1)) return cnt + 32'd1;
      return cnt;
   endfunction

   assign wr_hs  = awready && awvalid && wvalid;
   assign rd_hs  = arready && arvalid;
   assign wr_any = |wstrb;

   always_ff @(posedge clock) begin
      if (reset) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         // ready pulses only with address and data both present
         awready <= awvalid && wvalid && !awready && !bvalid;
         wready  <= awvalid && wvalid && !awready && !bvalid;
         arready <= arvalid && !arready && !rvalid;
         if (wr_hs) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rd_hs) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // responses and read data held with their valid
   always_ff @(posedge clock) begin
      if (wr_hs) begin
         bresp <= mapped(awaddr) ? resp_okay : resp_slverr;
      end
      if (rd_hs) begin
         rdata <= rd_word;
         rresp <= mapped(araddr) ? resp_okay : resp_slverr;
      end
   end

   always_comb begin
      rd_word = '0;
      case (araddr)
         reg_ctrl:     rd_word[ctrl_enable] = enable;
         reg_status: begin
            rd_word[st_link_up] = link_up;
            rd_word[st_aligned] = aligned;
         end
         reg_bursts:   rd_word = bursts;
         reg_len_err:  rd_word = len_errs;
         reg_skew_err: rd_word = skew_errs;
         reg_id:       rd_word = 32'(lanes);
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         enable    <= 1'b1;
         bursts    <= '0;
         len_errs  <= '0;
         skew_errs <= '0;
      end else begin
         if (wr_hs && wstrb[0] && (awaddr == reg_ctrl)) begin
            enable <= wdata[ctrl_enable];
         end
         bursts    <= next_count(bursts, burst_done,
                                 wr_hs && wr_any && (awaddr == reg_bursts));
         len_errs  <= next_count(len_errs, len_error,
                                 wr_hs && wr_any && (awaddr == reg_len_err));
         skew_errs <= next_count(skew_errs, skew_error,
                                 wr_hs && wr_any && (awaddr == reg_skew_err));
      end
   end

endmodule

//--- verilog/sl_burst_decode.sv
// burst decoder that turns aligned rows into framed beats and checks length
`timescale 1ns/1ns

module sl_burst_decode
   import sl_link_pkg::*;
#(
   parameter int lanes = 4
) (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      enable,
   input  logic                      row_valid,
   input  logic                      aligned,
   input  logic [lanes*word_w-1:0]   row_data,
   input  logic [lanes-1:0]          row_ctrl,
   output logic [lanes*word_w-1:0]   data,
   output logic [3:0]                sync,
   output logic                      valid,
   output logic                      start_of_burst,
   output logic                      end_of_burst,
   output logic                      link_up,
   output logic                      len_error,
   output logic                      burst_done
);

   lane_word_u              row_word;
   ctrl_word_t              cw;
   logic                    run;
   logic                    is_data;
   logic                    is_start;
   logic                    is_end;
   logic                    is_marker;
   logic                    flush;
   logic                    in_burst;
   logic                    sob_pending;
   logic                    seen_marker;
   logic [15:0]             row_cnt;
   logic [3:0]              sync_r;
   // one data row held back until the next row shows whether it ends the burst
   logic                    hold_valid;
   logic                    hold_sob;
   logic [3:0]              hold_sync;
   logic [lanes*word_w-1:0] hold_data;

   // lane 0 carries the control word
   assign row_word.raw = row_data[word_w-1:0];
   assign cw           = row_word.ctrl;
   assign run          = row_valid && enable;

   assign is_data   = run && !row_ctrl[0] && in_burst;
   assign is_start  = run && row_ctrl[0] && (cw.ctrl_type == ct_burst_start);
   assign is_end    = run && row_ctrl[0] && (cw.ctrl_type == ct_burst_end) && in_burst;
   assign is_marker = run && row_ctrl[0] &&
                      ((cw.ctrl_type == ct_idle) || (cw.ctrl_type == ct_align));
   // idle and align rows leave the held row in place
   assign flush     = hold_valid && (is_data || is_start || is_end);

   always_ff @(posedge clock) begin
      if (reset || !enable) begin
         valid          <= 1'b0;
         start_of_burst <= 1'b0;
         end_of_burst   <= 1'b0;
         len_error      <= 1'b0;
         burst_done     <= 1'b0;
         link_up        <= 1'b0;
         seen_marker    <= 1'b0;
         in_burst       <= 1'b0;
         sob_pending    <= 1'b0;
         hold_valid     <= 1'b0;
         hold_sob       <= 1'b0;
         row_cnt        <= '0;
      end else begin
         valid          <= flush;
         start_of_burst <= flush && hold_sob;
         end_of_burst   <= flush && is_end;
         burst_done     <= is_end;
         len_error      <= is_end && (cw.burst_len != row_cnt);
         link_up        <= aligned && seen_marker;
         if (!aligned) begin
            seen_marker <= 1'b0;
         end else if (is_marker) begin
            seen_marker <= 1'b1;
         end
         if (is_start) begin
            in_burst    <= 1'b1;
            sob_pending <= 1'b1;
            row_cnt     <= '0;
         end else if (is_end) begin
            in_burst    <= 1'b0;
         end
         if (is_data) begin
            hold_valid  <= 1'b1;
            hold_sob    <= sob_pending;
            sob_pending <= 1'b0;
            row_cnt     <= row_cnt + 16'd1;
         end else if (flush) begin
            hold_valid  <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (is_start) begin
         sync_r <= cw.sync;
      end
      if (is_data) begin
         hold_data <= row_data;
         hold_sync <= sync_r;
      end
      if (flush) begin
         data <= hold_data;
         sync <= hold_sync;
      end
   end

endmodule

//--- verilog/sl_lane_deskew.sv
// lane deskew that locks each lane on an align marker and emits aligned rows
`timescale 1ns/1ns

module sl_lane_deskew
   import sl_link_pkg::*;
#(
   parameter int lanes      = 4,
   parameter int fifo_depth = 8
) (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      enable,
   input  logic [lanes*word_w-1:0]   lane_data,
   input  logic [lanes-1:0]          lane_ctrl,
   input  logic [lanes-1:0]          lane_valid,
   output logic [lanes*word_w-1:0]   row_data,
   output logic [lanes-1:0]          row_ctrl,
   output logic                      row_valid,
   output logic                      aligned,
   output logic                      skew_error
);

   localparam int aw = $clog2(fifo_depth);

   // per lane skew fifo, ctrl bit stored above the word
   logic [word_w:0]  mem [lanes][fifo_depth];
   logic [aw-1:0]    wr_ptr [lanes];
   // all lanes pop together so one read pointer serves all
   logic [aw-1:0]    rd_ptr;
   logic [aw:0]      count [lanes];
   logic [lanes-1:0] locked;
   logic [lanes-1:0] is_marker;
   logic [lanes-1:0] wr;
   logic [lanes-1:0] full;
   logic [lanes-1:0] has_word;
   logic             pop;
   logic             overflow;
   lane_word_u       word [lanes];

   always_comb begin
      for (int i = 0; i < lanes; i++) begin
         word[i].raw  = lane_data[i*word_w +: word_w];
         is_marker[i] = lane_ctrl[i] && (word[i].ctrl.ctrl_type == ct_align);
         // search state drops everything up to the marker
         // marker itself goes in so the row shows up downstream
         wr[i]        = lane_valid[i] && (locked[i] || is_marker[i]);
         full[i]      = count[i] == (aw+1)'(fifo_depth);
         has_word[i]  = count[i] != '0;
      end
   end

   // one row per cycle once every lane has a word
   assign pop      = enable && (&locked) && (&has_word);
   // a simultaneous pop frees the slot
   assign overflow = enable && !pop && (|(wr & full));

   always_ff @(posedge clock) begin
      if (reset || !enable || overflow) begin
         // back to marker search with empty fifos
         locked <= '0;
         rd_ptr <= '0;
         for (int i = 0; i < lanes; i++) begin
            wr_ptr[i] <= '0;
            count[i]  <= '0;
         end
      end else begin
         for (int i = 0; i < lanes; i++) begin
            if (wr[i]) begin
               locked[i] <= 1'b1;
               wr_ptr[i] <= wr_ptr[i] + 1'b1;
            end
            count[i] <= count[i] + (aw+1)'(wr[i]) - (aw+1)'(pop);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // fifo storage
   always_ff @(posedge clock) begin
      for (int i = 0; i < lanes; i++) begin
         if (wr[i]) begin
            mem[i][wr_ptr[i]] <= {lane_ctrl[i], lane_data[i*word_w +: word_w]};
         end
      end
   end

   // registered row out, one cycle after the last lane fills
   always_ff @(posedge clock) begin
      if (reset) begin
         row_valid  <= 1'b0;
         aligned    <= 1'b0;
         skew_error <= 1'b0;
      end else begin
         row_valid  <= pop;
         skew_error <= overflow;
         aligned    <= enable && !overflow && (&locked);
      end
   end

   always_ff @(posedge clock) begin
      for (int i = 0; i < lanes; i++) begin
         if (pop) begin
            row_data[i*word_w +: word_w] <= mem[i][rd_ptr][word_w-1:0];
            row_ctrl[i]                  <= mem[i][rd_ptr][word_w];
         end
      end
   end

endmodule

//--- verilog/sl_mgmt_pkg.sv
// management package with register map, axi response codes and bit positions
package sl_mgmt_pkg;

   // register byte offsets
   localparam logic [7:0] reg_ctrl     = 8'h00;
   localparam logic [7:0] reg_status   = 8'h04;
   localparam logic [7:0] reg_bursts   = 8'h08;
   localparam logic [7:0] reg_len_err  = 8'h0C;
   localparam logic [7:0] reg_skew_err = 8'h10;
   localparam logic [7:0] reg_id       = 8'h14;

   // axi response codes
   localparam logic [1:0] resp_okay    = 2'd0;
   localparam logic [1:0] resp_slverr  = 2'd2;

   // bit in reg_ctrl
   localparam int ctrl_enable = 0;

   // bits in reg_status
   localparam int st_link_up  = 0;
   localparam int st_aligned  = 1;

endpackage

//--- verilog/sl_link_pkg.sv
// link layer package with lane word formats and control word decoding
package sl_link_pkg;

   // width of one deserialized lane word
   localparam int word_w = 64;

   // control word type codes
   // carried in the top nibble of a control word
   typedef enum logic [3:0] {
      ct_idle        = 4'h0,
      ct_align       = 4'h1,
      ct_burst_start = 4'h2,
      ct_burst_end   = 4'h3
   } ctrl_type_e;

   // control word layout, msb first
   typedef struct packed {
      // bits 63:60
      ctrl_type_e  ctrl_type;
      // bits 59:56
      // sync field of burst start
      logic [3:0]  sync;
      // bits 55:40
      // data rows in the burst, checked at burst end
      logic [15:0] burst_len;
      // bits 39:0, not decoded
      logic [39:0] reserved;
   } ctrl_word_t;

   // one lane word, two views
   // lane ctrl bit picks which one applies
   typedef union packed {
      // payload view for data words
      logic [word_w-1:0] raw;
      // control view when ctrl bit set
      ctrl_word_t        ctrl;
   } lane_word_u;

endpackage
